// File: design/dcache_controller.sv
`timescale 1ns/1ps

module dcache_controller (
    input  logic                               clk,
    input  logic                               reset,

    // cpu side
    input  logic                               cpu_req,
    input  logic                               cpu_we,
    input  logic [dcache_pkg::addr_width-1:0]  cpu_addr,
    output logic                               cpu_data_ok,

    // from the line store
    input  logic                               hit,
    input  logic                               dirty,
    input  logic [dcache_pkg::tag_bits-1:0]    victim_tag,
    input  logic [dcache_pkg::data_width-1:0]  victim_word,

    // to the line store
    output dcache_pkg::ctrl_state_t            state,
    output logic [dcache_pkg::word_sel_bits-1:0] fill_word,
    output logic                               line_we,
    output logic                               cpu_we_hit,
    output logic                               set_valid,
    output logic                               new_dirty,

    // memory side, one word per request
    output logic                               mem_req,
    output logic                               mem_we,
    output logic [dcache_pkg::addr_width-1:0]  mem_addr,
    output logic [dcache_pkg::data_width-1:0]  mem_wdata,
    input  logic                               mem_addr_ok,
    input  logic                               mem_data_ok
);

    import dcache_pkg::*;

    logic [word_sel_bits-1:0] word_cnt;   // word of the line in flight
    logic                     addr_done;  // address phase of current beat accepted
    logic                     in_burst;
    logic                     beat_done;
    logic                     last_word;
    logic                     new_access;

    logic [index_bits-1:0]    index;
    logic [tag_bits-1:0]      req_tag;
    logic [tag_bits-1:0]      beat_tag;

    assign index   = cpu_addr[offset_bits +: index_bits];
    assign req_tag = cpu_addr[addr_width-1 -: tag_bits];

    assign in_burst  = (state == st_writeback) || (state == st_refill);
    assign last_word = (word_cnt == word_sel_bits'(words_per_line - 1));

    // fresh request, the cycle with cpu_data_ok high still shows the old one
    assign new_access = (state == st_idle) && cpu_req && !cpu_data_ok;

    // data_ok may arrive in the same cycle as addr_ok
    assign beat_done = in_burst && mem_data_ok && (addr_done || (mem_req && mem_addr_ok));

    // main state machine and beat tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            mem_req     <= 1'b0;
            addr_done   <= 1'b0;
            word_cnt    <= '0;
            cpu_data_ok <= 1'b0;
        end else begin
            cpu_data_ok <= 1'b0;  // single cycle pulse

            case (state)
                st_idle: begin
                    if (new_access) begin
                        if (hit) begin
                            cpu_data_ok <= 1'b1;  // hit, answer next cycle
                        end else begin
                            state     <= dirty ? st_writeback : st_refill;
                            mem_req   <= 1'b1;
                            word_cnt  <= '0;
                            addr_done <= 1'b0;
                        end
                    end
                end

                st_writeback,
                st_refill: begin
                    if (mem_req && mem_addr_ok) begin
                        mem_req   <= 1'b0;
                        addr_done <= 1'b1;
                    end

                    // a beat ends on mem_data_ok only, late strobes just stretch it
                    if (beat_done) begin
                        addr_done <= 1'b0;
                        if (last_word) begin
                            word_cnt <= '0;
                            if (state == st_writeback) begin
                                state   <= st_refill;  // victim out, now fetch
                                mem_req <= 1'b1;
                            end else begin
                                state   <= st_respond;
                                mem_req <= 1'b0;
                            end
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            mem_req  <= 1'b1;  // next word of the line
                        end
                    end
                end

                st_respond: begin
                    state       <= st_idle;
                    cpu_data_ok <= 1'b1;
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign fill_word = word_cnt;

    // writeback targets the victim line, refill the requested one
    assign beat_tag = (state == st_writeback) ? victim_tag : req_tag;

    assign mem_addr = {beat_tag, index, word_cnt, {(offset_bits - word_sel_bits){1'b0}}};

    assign mem_we    = (state == st_writeback);
    assign mem_wdata = victim_word;

    // refill writes each returned word into the line
    assign line_we = (state == st_refill) && beat_done;

    // tag and valid are set with the last refill word
    assign set_valid = line_we && last_word;

    // cpu store goes into the line on a hit or once the refill is done
    assign cpu_we_hit = cpu_we && ((new_access && hit) || (state == st_respond));

    // a store marks the line dirty, a refill leaves it clean
    assign new_dirty = cpu_we_hit;

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    // address and word geometry
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // line layout: 16 bytes per line, 4 words
    localparam int offset_bits    = 4;
    localparam int words_per_line = 4;
    localparam int word_sel_bits  = 2;

    // direct mapped, 16 lines
    localparam int index_bits = 4;
    localparam int num_lines  = 16;

    localparam int tag_bits  = addr_width - index_bits - offset_bits;  // 24
    localparam int line_bits = words_per_line * data_width;            // 128

    // cpu access size, matches the cpu_size port encoding
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    // miss handling states
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_writeback = 2'd1,  // dirty victim goes out first
        st_refill    = 2'd2,
        st_respond   = 2'd3   // finish the cpu access after refill
    } ctrl_state_t;

endpackage

// File: design/dcache_store.sv
`timescale 1ns/1ps

module dcache_store (
    input  logic                                 clk,
    input  logic                                 reset,

    // cpu request fields
    input  logic [dcache_pkg::addr_width-1:0]    cpu_addr,
    input  dcache_pkg::size_t                    cpu_size,
    input  logic [dcache_pkg::data_width-1:0]    cpu_wdata,
    output logic [dcache_pkg::data_width-1:0]    cpu_rdata,

    // controls from the controller
    input  dcache_pkg::ctrl_state_t              state,
    input  logic [dcache_pkg::word_sel_bits-1:0] fill_word,
    input  logic                                 line_we,
    input  logic                                 cpu_we_hit,
    input  logic                                 set_valid,
    input  logic                                 new_dirty,

    // refill data from memory
    input  logic [dcache_pkg::data_width-1:0]    mem_rdata,

    // status back to the controller
    output logic                                 hit,
    output logic                                 dirty,
    output logic [dcache_pkg::tag_bits-1:0]      victim_tag,
    output logic [dcache_pkg::data_width-1:0]    victim_word
);

    import dcache_pkg::*;

    localparam int num_lanes = data_width / 8;

    // line arrays
    logic [tag_bits-1:0]  tag_mem  [num_lines];
    logic [line_bits-1:0] data_mem [num_lines];
    logic [num_lines-1:0] valid;
    logic [num_lines-1:0] dirty_bits;

    // address decode
    logic [tag_bits-1:0]      cpu_tag;
    logic [index_bits-1:0]    index;
    logic [word_sel_bits-1:0] cpu_word;
    logic [1:0]               byte_off;

    logic [word_sel_bits-1:0] wr_sel;
    logic [data_width-1:0]    old_word;
    logic [data_width-1:0]    merged_word;
    logic [num_lanes-1:0]     byte_en;

    assign cpu_tag  = cpu_addr[addr_width-1 -: tag_bits];
    assign index    = cpu_addr[offset_bits +: index_bits];
    assign cpu_word = cpu_addr[offset_bits-word_sel_bits +: word_sel_bits];
    assign byte_off = cpu_addr[1:0];

    // lookup
    assign hit        = valid[index] && (tag_mem[index] == cpu_tag);
    assign dirty      = valid[index] && dirty_bits[index];
    assign victim_tag = tag_mem[index];

    assign old_word    = data_mem[index][cpu_word*data_width +: data_width];
    assign cpu_rdata   = old_word;  // whole word, cpu picks the lanes
    assign victim_word = data_mem[index][fill_word*data_width +: data_width];

    // lanes touched by the store
    always_comb begin
        case (cpu_size)
            size_byte: byte_en = num_lanes'(4'b0001 << byte_off);
            size_half: byte_en = num_lanes'(4'b0011 << {byte_off[1], 1'b0});
            default:   byte_en = '1;
        endcase
    end

    // store data already sits in its byte lanes
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            merged_word[i*8 +: 8] = byte_en[i] ? cpu_wdata[i*8 +: 8] : old_word[i*8 +: 8];
        end
    end

    // refill walks the line, a cpu store hits its own word
    assign wr_sel = (state == st_refill) ? fill_word : cpu_word;

    always_ff @(posedge clk) begin
        if (line_we) begin
            data_mem[index][wr_sel*data_width +: data_width] <= mem_rdata;
        end else if (cpu_we_hit) begin
            data_mem[index][wr_sel*data_width +: data_width] <= merged_word;
        end
    end

    always_ff @(posedge clk) begin
        if (set_valid) begin
            tag_mem[index] <= cpu_tag;  // new owner of the line
        end
    end

    // valid and dirty flags
    always_ff @(posedge clk) begin
        if (reset) begin
            valid      <= '0;
            dirty_bits <= '0;
        end else begin
            if (set_valid) begin
                valid[index] <= 1'b1;
            end
            if (set_valid || cpu_we_hit) begin
                dirty_bits[index] <= new_dirty;  // cleared on refill, set by a store
            end
        end
    end

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                              clk,
    input  logic                              reset,

    // cpu port
    input  logic                              cpu_req,
    input  logic                              cpu_we,
    input  logic [dcache_pkg::addr_width-1:0] cpu_addr,
    input  dcache_pkg::size_t                 cpu_size,
    input  logic [dcache_pkg::data_width-1:0] cpu_wdata,
    output logic [dcache_pkg::data_width-1:0] cpu_rdata,
    output logic                              cpu_data_ok,

    // memory port
    output logic                              mem_req,
    output logic                              mem_we,
    output logic [dcache_pkg::addr_width-1:0] mem_addr,
    output logic [dcache_pkg::data_width-1:0] mem_wdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    input  logic [dcache_pkg::data_width-1:0] mem_rdata
);

    import dcache_pkg::*;

    // controller <-> store
    ctrl_state_t              state;
    logic [word_sel_bits-1:0] fill_word;
    logic                     line_we;
    logic                     cpu_we_hit;
    logic                     set_valid;
    logic                     new_dirty;
    logic                     hit;
    logic                     dirty;
    logic [tag_bits-1:0]      victim_tag;
    logic [data_width-1:0]    victim_word;

    dcache_controller ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_data_ok (cpu_data_ok),
        .hit         (hit),
        .dirty       (dirty),
        .victim_tag  (victim_tag),
        .victim_word (victim_word),
        .state       (state),
        .fill_word   (fill_word),
        .line_we     (line_we),
        .cpu_we_hit  (cpu_we_hit),
        .set_valid   (set_valid),
        .new_dirty   (new_dirty),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

    dcache_store store0 (
        .clk         (clk),
        .reset       (reset),
        .cpu_addr    (cpu_addr),
        .cpu_size    (cpu_size),
        .cpu_wdata   (cpu_wdata),
        .cpu_rdata   (cpu_rdata),
        .state       (state),
        .fill_word   (fill_word),
        .line_we     (line_we),
        .cpu_we_hit  (cpu_we_hit),
        .set_valid   (set_valid),
        .new_dirty   (new_dirty),
        .mem_rdata   (mem_rdata),
        .hit         (hit),
        .dirty       (dirty),
        .victim_tag  (victim_tag),
        .victim_word (victim_word)
    );

endmodule

// File: dv/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [2:0]                        addr_delay,  // cycles before mem_addr_ok
    input  logic [2:0]                        data_delay,  // cycles before mem_data_ok
    input  logic                              mem_req,
    input  logic                              mem_we,
    input  logic [dcache_pkg::addr_width-1:0] mem_addr,
    input  logic [dcache_pkg::data_width-1:0] mem_wdata,
    output logic                              mem_addr_ok,
    output logic                              mem_data_ok,
    output logic [dcache_pkg::data_width-1:0] mem_rdata
);

    localparam int mem_words = 4096;

    typedef enum logic [1:0] {ph_idle, ph_addr, ph_data} phase_t;

    logic [31:0] mem [mem_words];
    phase_t      phase;
    logic [2:0]  wait_cnt;
    logic [11:0] word_addr;
    logic        we_q;
    logic [31:0] wdata_q;

    // every word starts out holding its own byte address
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'(i) << 2;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            phase       <= ph_idle;
            wait_cnt    <= '0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            if ((phase == ph_idle && mem_req && addr_delay == 0) ||
                (phase == ph_addr && wait_cnt == 0)) begin
                mem_addr_ok <= 1'b1;  // accept the word request
                word_addr   <= mem_addr[13:2];
                we_q        <= mem_we;
                wdata_q     <= mem_wdata;
                wait_cnt    <= data_delay;
                phase       <= ph_data;
            end else if (phase == ph_idle && mem_req) begin
                wait_cnt <= addr_delay - 1'b1;
                phase    <= ph_addr;
            end else if (phase == ph_addr) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else if (phase == ph_data && wait_cnt == 0) begin
                mem_data_ok <= 1'b1;
                mem_rdata   <= mem[word_addr];
                if (we_q) begin
                    mem[word_addr] <= wdata_q;
                end
                phase <= ph_idle;
            end else if (phase == ph_data) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int cpu_timeout = 400;   // cycles allowed per access
    localparam int ref_words   = 1024;  // 4 KB window under test

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  cpu_req;
    logic                  cpu_we;
    logic [addr_width-1:0] cpu_addr;
    size_t                 cpu_size;
    logic [data_width-1:0] cpu_wdata;
    logic [data_width-1:0] cpu_rdata;
    logic                  cpu_data_ok;
    logic                  mem_req;
    logic                  mem_we;
    logic [addr_width-1:0] mem_addr;
    logic [data_width-1:0] mem_wdata;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [data_width-1:0] mem_rdata;
    logic [2:0]            addr_delay;
    logic [2:0]            data_delay;

    // reference model state
    logic [31:0]          ref_mem [ref_words];
    logic [tag_bits-1:0]  shadow_tag [num_lines];
    logic [num_lines-1:0] shadow_valid;
    logic [num_lines-1:0] shadow_dirty;
    logic [31:0]          exp_wb_addr [$];
    logic [31:0]          exp_wb_data [$];
    logic [31:0]          obs_wb_addr [$];
    logic [31:0]          obs_wb_data [$];

    logic [31:0] stim_rng  = 32'd96;
    logic [31:0] delay_rng = 32'd96;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          accesses = 0;

    always #50 clk = ~clk;

    dcache_top dut0 (.*);

    dcache_mem_model mem0 (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // byte lanes written follow size and the low address bits
    function automatic logic [31:0] apply_store(input logic [31:0] old, input logic [31:0] data,
                                                input size_t size, input logic [1:0] off);
        logic [31:0] res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (size == size_word || (size == size_half && lane / 2 == off[1]) ||
                (size == size_byte && lane == off)) begin
                res[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return res;
    endfunction

    // new memory delays every cycle, 0 to 5
    always @(negedge clk) begin
        delay_rng  = xorshift32(delay_rng);
        addr_delay = 3'(delay_rng % 6);
        delay_rng  = xorshift32(delay_rng);
        data_delay = 3'(delay_rng % 6);
    end

    // accepted memory writes, one per beat
    always @(negedge clk) begin
        if (mem_req && mem_we && mem_addr_ok) begin
            obs_wb_addr.push_back(mem_addr);
            obs_wb_data.push_back(mem_wdata);
        end
    end

    task automatic finish_run();
        $display("summary: %0d tests, %0d failed, %0d accesses, %0d errors",
                 tests_run, tests_failed, accesses, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic close_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %-10s ok", name);
        end else begin
            tests_failed++;
            $display("test %-10s %0d errors", name, errors - err_mark);
        end
    endtask

    // one cpu access, checked against the shadow tags and the memory image
    task automatic do_access(input logic we, input logic [31:0] addr, input size_t size,
                             input logic [31:0] wdata);
        logic [index_bits-1:0] index;
        logic [tag_bits-1:0]   tag;
        logic                  exp_hit;
        logic                  saw_mem_req;
        logic [31:0]           victim_addr;
        int                    cycles;

        index   = addr[offset_bits +: index_bits];
        tag     = addr[addr_width-1 -: tag_bits];
        exp_hit = shadow_valid[index] && (shadow_tag[index] == tag);
        exp_wb_addr.delete();
        exp_wb_data.delete();
        obs_wb_addr.delete();
        obs_wb_data.delete();
        if (!exp_hit && shadow_valid[index] && shadow_dirty[index]) begin
            for (int w = 0; w < words_per_line; w++) begin
                victim_addr = {shadow_tag[index], index, 2'(w), 2'b00};
                exp_wb_addr.push_back(victim_addr);
                exp_wb_data.push_back(ref_mem[victim_addr[11:2]]);
            end
        end

        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_size  = size;
        cpu_wdata = wdata;
        accesses++;
        cycles      = 0;
        saw_mem_req = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (mem_req) saw_mem_req = 1'b1;
        end while (!cpu_data_ok && cycles < cpu_timeout);

        if (!cpu_data_ok) begin
            $display("timeout at %0t: no cpu_data_ok for address %h within %0d cycles",
                     $time, addr, cpu_timeout);
            errors++;
            finish_run();
        end else begin
            if (exp_hit && cycles != 1) begin
                $display("ERROR t=%0t cpu_data_ok latency expected 1 got %0d", $time, cycles);
                errors++;
            end
            if (exp_hit && saw_mem_req) begin
                $display("memory request issued on a hit to %h at %0t", addr, $time);
                errors++;
            end
            if (!exp_hit && !saw_mem_req) begin
                $display("miss to %h answered without a memory request at %0t", addr, $time);
                errors++;
            end
            if (!we) begin
                if (cpu_rdata !== ref_mem[addr[11:2]]) begin
                    $display("ERROR t=%0t cpu_rdata expected %h got %h",
                             $time, ref_mem[addr[11:2]], cpu_rdata);
                    errors++;
                end
            end else begin
                ref_mem[addr[11:2]] = apply_store(ref_mem[addr[11:2]], wdata, size, addr[1:0]);
            end
            if (obs_wb_addr.size() != exp_wb_addr.size()) begin
                $display("ERROR t=%0t mem_we write count expected %0d got %0d",
                         $time, exp_wb_addr.size(), obs_wb_addr.size());
                errors++;
            end else begin
                foreach (exp_wb_addr[i]) begin
                    if (obs_wb_addr[i] !== exp_wb_addr[i]) begin
                        $display("ERROR t=%0t mem_addr expected %h got %h",
                                 $time, exp_wb_addr[i], obs_wb_addr[i]);
                        errors++;
                    end
                    if (obs_wb_data[i] !== exp_wb_data[i]) begin
                        $display("ERROR t=%0t mem_wdata expected %h got %h",
                                 $time, exp_wb_data[i], obs_wb_data[i]);
                        errors++;
                    end
                end
            end
            if (!exp_hit) begin
                shadow_valid[index] = 1'b1;
                shadow_tag[index]   = tag;
                shadow_dirty[index] = 1'b0;
            end
            if (we) shadow_dirty[index] = 1'b1;
            @(negedge clk);  // request stays up through the cpu_data_ok cycle
            cpu_req = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] r;
        int          err_mark;

        reset      = 1'b1;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_size   = size_word;
        cpu_wdata  = '0;
        addr_delay = '0;
        data_delay = '0;
        shadow_valid = '0;
        shadow_dirty = '0;
        for (int i = 0; i < ref_words; i++) begin
            ref_mem[i] = 32'(i) << 2;  // same fill as the memory model
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        err_mark = errors;
        if (mem_req !== 1'b0) begin
            $display("ERROR t=%0t mem_req expected 0 got %b", $time, mem_req);
            errors++;
        end
        if (cpu_data_ok !== 1'b0) begin
            $display("ERROR t=%0t cpu_data_ok expected 0 got %b", $time, cpu_data_ok);
            errors++;
        end
        do_access(1'b0, next_random() & 32'hfff, size_word, '0);
        close_test("reset", err_mark);

        err_mark = errors;
        for (int i = 0; i < 8; i++) begin
            addr = next_random() & 32'hfff;
            do_access(1'b0, addr, size_word, '0);
            do_access(1'b0, addr, size_word, '0);  // now a hit
        end
        close_test("hit", err_mark);

        err_mark = errors;
        for (int i = 0; i < 40; i++) begin
            addr = next_random() & 32'hfff;
            do_access(1'b1, addr, size_t'(next_random() % 3), next_random());
            do_access(1'b0, addr, size_word, '0);
        end
        close_test("subword", err_mark);

        // dirty line, then a dirty eviction, then a clean one on the same index
        err_mark = errors;
        for (int i = 0; i < 4; i++) begin
            addr = next_random() & 32'hff0;
            do_access(1'b1, addr, size_word, next_random());
            do_access(1'b0, addr ^ 32'h100, size_word, '0);
            do_access(1'b0, addr ^ 32'h200, size_word, '0);
        end
        close_test("writeback", err_mark);

        err_mark = errors;
        for (int i = 0; i < 500; i++) begin
            r = next_random();
            do_access(r[31], next_random() & 32'hfff, size_t'(r % 3), next_random());
        end
        close_test("random", err_mark);

        finish_run();
    end

endmodule

// File: verilog.f
design/dcache_pkg.sv
design/dcache_controller.sv
design/dcache_store.sv
design/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv
